// File: source/afu_edge_pkg.sv
`default_nettype none

package afu_edge_pkg;

    // ========================================
    // Widths and sizes
    // ========================================

    // Write data carried by one AFU beat
    localparam int DATA_W = 64;

    // Line address width
    localparam int ADDR_W = 32;

    // The write heap holds one packet of data per index
    localparam int HEAP_ENTRIES = 32;
    localparam int HEAP_IDX_W = $clog2(HEAP_ENTRIES);

    // Multi-beat packets carry one to four lines
    localparam int MAX_BEATS = 4;

    // The length field encodes beats minus one
    localparam int CL_LEN_W = $clog2(MAX_BEATS);

    // ========================================
    // Flow control thresholds
    // ========================================

    // Beats the AFU may still send after it sees almost-full
    localparam int ALMOST_FULL_THRESHOLD = 8;

    // Reserve enough indices for the threshold plus one whole packet, since
    // almost-full is never raised in the middle of a packet
    localparam int MIN_FREE_SLOTS = ALMOST_FULL_THRESHOLD + MAX_BEATS + 1;

    // ========================================
    // Packed structs
    // ========================================

    // One write beat from the AFU
    typedef struct packed {
        logic                valid;
        logic                sop;
        logic [CL_LEN_W-1:0] cl_len;
        logic [ADDR_W-1:0]   address;
        logic [DATA_W-1:0]   data;
    } wr_beat_t;

    // One write into the external data heap
    typedef struct packed {
        logic                  wen;
        logic [HEAP_IDX_W-1:0] idx;
        logic [CL_LEN_W-1:0]   cl_num;
        logic [DATA_W-1:0]     data;
    } heap_write_t;

    // The single control flit sent down the pipeline for each packet
    typedef struct packed {
        logic                  valid;
        logic [CL_LEN_W-1:0]   cl_len;
        logic [ADDR_W-1:0]     address;
        logic [HEAP_IDX_W-1:0] heap_idx;
    } wr_ctrl_t;

    // Header fields recovered from the start-of-packet beat
    typedef struct packed {
        logic [CL_LEN_W-1:0] cl_len;
        logic [ADDR_W-1:0]   address;
    } wr_hdr_t;

endpackage

`default_nettype wire

// File: source/write_heap_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

// Free list of write-heap indices, kept as a circular FIFO
module write_heap_ctrl
(
    input  logic                                clk,
    input  logic                                reset,

    // Pop the head index at the end of a packet
    input  logic                                alloc,
    output logic [afu_edge_pkg::HEAP_IDX_W-1:0] alloc_idx,
    output logic                                not_full,

    // Return an index to the tail of the list
    input  logic                                free,
    input  logic [afu_edge_pkg::HEAP_IDX_W-1:0] free_idx
);

    // ========================================
    // Free-list storage
    // ========================================

    // Every index can be free at once, so the list is as deep as the heap
    logic [afu_edge_pkg::HEAP_IDX_W-1:0] list_mem [afu_edge_pkg::HEAP_ENTRIES];

    // Pointers wrap by themselves because the heap size is a power of two
    logic [afu_edge_pkg::HEAP_IDX_W-1:0] head;
    logic [afu_edge_pkg::HEAP_IDX_W-1:0] tail;

    // One extra bit so that a completely free heap can be counted
    logic [afu_edge_pkg::HEAP_IDX_W:0]   free_cnt;

    // Gate pops on an empty list so the count can never wrap below zero
    logic                                do_pop;

    assign do_pop = alloc && (free_cnt != '0);

    // The head entry is the index the current packet writes into
    assign alloc_idx = list_mem[head];

    // Report room only while the reserve is still intact
    assign not_full = (free_cnt > afu_edge_pkg::MIN_FREE_SLOTS);

    // ========================================
    // List update
    // ========================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            // After reset the list holds every index in ascending order
            for (int i = 0; i < afu_edge_pkg::HEAP_ENTRIES; i++)
            begin
                list_mem[i] <= afu_edge_pkg::HEAP_IDX_W'(i);
            end
        end
        else if (free)
        begin
            // Released indices join the tail
            list_mem[tail] <= free_idx;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            head <= '0;
            // A full list has tail equal to head
            tail <= '0;
            free_cnt <= (afu_edge_pkg::HEAP_IDX_W+1)'(afu_edge_pkg::HEAP_ENTRIES);
        end
        else
        begin
            if (do_pop)
            begin
                head <= head + 1'b1;
            end

            if (free)
            begin
                tail <= tail + 1'b1;
            end

            // Simultaneous pop and push leave the count unchanged
            if (do_pop && !free)
            begin
                free_cnt <= free_cnt - 1'b1;
            end
            else if (free && !do_pop)
            begin
                free_cnt <= free_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/write_packet_tracker.sv
`timescale 1ns/1ps
`default_nettype none

// Follows the beats of multi-beat writes and recovers the start header
module write_packet_tracker
(
    input  logic                              clk,
    input  logic                              reset,

    input  afu_edge_pkg::wr_beat_t            beat,

    // Header of the packet the current beat belongs to
    output afu_edge_pkg::wr_hdr_t             hdr,
    // Beat number within the packet
    output logic [afu_edge_pkg::CL_LEN_W-1:0] cl_num,
    // Current beat is the last one of its packet
    output logic                              eop,
    // High from after a start beat until its end beat is seen
    output logic                              packet_active
);

    // ========================================
    // Start-of-packet header
    // ========================================

    // Address and length of non-start beats are don't care on the bus,
    // so the start beat's values are kept here
    afu_edge_pkg::wr_hdr_t sop_hdr;

    always_ff @(posedge clk)
    begin
        if (beat.valid && beat.sop)
        begin
            sop_hdr.cl_len <= beat.cl_len;
            sop_hdr.address <= beat.address;
        end
    end

    // The start beat brings its own header, later beats reuse the saved one
    always_comb
    begin
        if (beat.sop)
        begin
            hdr.cl_len = beat.cl_len;
            hdr.address = beat.address;
        end
        else
        begin
            hdr = sop_hdr;
        end
    end

    // ========================================
    // Beat counting
    // ========================================

    logic [afu_edge_pkg::CL_LEN_W-1:0] beat_cnt;
    logic                              active;

    // The counter returns to zero after every packet, so a start beat sees 0
    assign cl_num = beat_cnt;
    assign eop = (beat_cnt == hdr.cl_len);
    assign packet_active = active;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            beat_cnt <= '0;
            active <= 1'b0;
        end
        else if (beat.valid)
        begin
            if (eop)
            begin
                // Last beat closes the packet
                beat_cnt <= '0;
                active <= 1'b0;
            end
            else
            begin
                beat_cnt <= beat_cnt + 1'b1;
                active <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/write_flow_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

// Registered almost-full level toward the AFU
module write_flow_ctrl
(
    input  logic clk,
    input  logic reset,

    input  logic pipe_almost_full,
    input  logic heap_not_full,
    input  logic packet_active,

    output logic afu_almost_full
);

    // Raw back-pressure from the pipeline or a low heap
    logic cond;

    // Remembers that almost-full was already raised outside a packet
    logic sticky;

    assign cond = pipe_almost_full || !heap_not_full;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            // The AFU must hold off until the edge is out of reset
            afu_almost_full <= 1'b1;
            sticky <= 1'b0;
        end
        else
        begin
            // A rise in the middle of a packet could deadlock, since its
            // control flit is not yet in the pipeline
            afu_almost_full <= cond && (!packet_active || sticky);

            // Sticky sets between packets and holds until cond drops
            if (!cond)
            begin
                sticky <= 1'b0;
            end
            else if (!packet_active)
            begin
                sticky <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/write_request_collapse.sv
`timescale 1ns/1ps
`default_nettype none

// Sends one control flit per packet, once all of its beats are in the heap
module write_request_collapse
(
    input  logic                                clk,
    input  logic                                reset,

    input  logic                                beat_valid,
    input  logic                                eop,
    input  afu_edge_pkg::wr_hdr_t               hdr,
    input  logic [afu_edge_pkg::HEAP_IDX_W-1:0] heap_idx,

    output afu_edge_pkg::wr_ctrl_t              ctrl
);

    // ========================================
    // Control flit register
    // ========================================

    // Only the final beat passes, which guarantees all the data for the
    // packet is already in the heap when the flit leaves
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ctrl.valid <= 1'b0;
        end
        else
        begin
            ctrl.valid <= beat_valid && eop;
        end
    end

    // Payload follows the final beat; other beats never reach the pipeline
    always_ff @(posedge clk)
    begin
        if (beat_valid && eop)
        begin
            // Header comes from the start beat, even for multi-beat packets
            ctrl.cl_len <= hdr.cl_len;
            ctrl.address <= hdr.address;

            // Downstream uses the index to fetch the data and to free it
            ctrl.heap_idx <= heap_idx;
        end
    end

endmodule

`default_nettype wire

// File: source/afu_write_edge.sv
`timescale 1ns/1ps
`default_nettype none

// AFU-side edge of the write channel
module afu_write_edge
(
    input  logic                                clk,
    input  logic                                reset,

    // AFU side
    input  afu_edge_pkg::wr_beat_t              afu_beat,
    output logic                                afu_almost_full,

    // Downstream side
    input  logic                                pipe_almost_full,
    input  logic                                free,
    input  logic [afu_edge_pkg::HEAP_IDX_W-1:0] free_idx,

    output afu_edge_pkg::heap_write_t           heap_wr,
    output afu_edge_pkg::wr_ctrl_t              pipe_ctrl
);

    logic [afu_edge_pkg::HEAP_IDX_W-1:0] alloc_idx;
    logic                                heap_not_full;
    afu_edge_pkg::wr_hdr_t               hdr;
    logic [afu_edge_pkg::CL_LEN_W-1:0]   cl_num;
    logic                                eop;
    logic                                packet_active;

    // ========================================
    // Heap index allocation
    // ========================================

    // All beats share the head index, which is popped on the last beat
    write_heap_ctrl heap_ctrl_i
    (
        .clk,
        .reset,
        .alloc(afu_beat.valid && eop),
        .alloc_idx,
        .not_full(heap_not_full),
        .free,
        .free_idx
    );

    // Beat data goes to the heap in the same cycle it arrives
    assign heap_wr.wen = afu_beat.valid;
    assign heap_wr.idx = alloc_idx;
    assign heap_wr.cl_num = cl_num;
    assign heap_wr.data = afu_beat.data;

    // ========================================
    // Packet tracking and flow
    // ========================================

    write_packet_tracker packet_tracker_i
    (
        .clk,
        .reset,
        .beat(afu_beat),
        .hdr,
        .cl_num,
        .eop,
        .packet_active
    );

    write_flow_ctrl flow_ctrl_i
    (
        .clk,
        .reset,
        .pipe_almost_full,
        .heap_not_full,
        .packet_active,
        .afu_almost_full
    );

    write_request_collapse request_collapse_i
    (
        .clk,
        .reset,
        .beat_valid(afu_beat.valid),
        .eop,
        .hdr,
        .heap_idx(alloc_idx),
        .ctrl(pipe_ctrl)
    );

endmodule

`default_nettype wire

// File: test/afu_write_edge_assertions.sv
`timescale 1ns/1ps
`default_nettype none

// Packet format checks on the AFU write beats, bound into the tracker
module afu_write_edge_assertions
(
    input logic                   clk,
    input logic                   reset,
    input afu_edge_pkg::wr_beat_t beat,
    input logic                   packet_active
);

    // A new packet may only start once the previous one has ended
    sop_while_active: assert property (@(posedge clk) disable iff (reset)
        (beat.valid && beat.sop) |-> !packet_active)
        else $error("Start beat arrived while a packet was open");

    // Continuation beats only make sense inside an open packet
    nonsop_while_idle: assert property (@(posedge clk) disable iff (reset)
        (beat.valid && !beat.sop) |-> packet_active)
        else $error("Non-start beat arrived with no packet open");

    // Two-line packets align to two lines, three and four lines align to four
    sop_aligned: assert property (@(posedge clk) disable iff (reset)
        (beat.valid && beat.sop) |->
            ((beat.address[0] & (beat.cl_len[0] | beat.cl_len[1])) == 1'b0) &&
            ((beat.address[1] & beat.cl_len[1]) == 1'b0))
        else $error("Start beat address not aligned to its line count");

endmodule

bind write_packet_tracker afu_write_edge_assertions packet_assertions_i
(
    .clk(clk),
    .reset(reset),
    .beat(beat),
    .packet_active(packet_active)
);

`default_nettype wire

// File: test/afu_write_edge_tb.sv
`timescale 1ns/1ps
`default_nettype none

module afu_write_edge_tb;

    localparam int TIMEOUT = 200;

    logic                                clk;
    logic                                reset;
    afu_edge_pkg::wr_beat_t              afu_beat;
    logic                                afu_almost_full;
    logic                                pipe_almost_full;
    logic                                free;
    logic [afu_edge_pkg::HEAP_IDX_W-1:0] free_idx;
    afu_edge_pkg::heap_write_t           heap_wr;
    afu_edge_pkg::wr_ctrl_t              pipe_ctrl;

    integer seed = 62;
    int     errors = 0;
    int     failed_tests = 0;
    int     test_count = 0;
    int     free_pct = 0;
    int     packets = 0;
    int     flits = 0;
    int     test_errors;
    int     test_packets;
    int     test_flits;

    // ========================================
    // Reference model state
    // ========================================

    // Free list in FIFO order and the indices the downstream end still holds
    logic [afu_edge_pkg::HEAP_IDX_W-1:0] free_q [$];
    logic [afu_edge_pkg::HEAP_IDX_W-1:0] used_q [$];
    logic                                m_active;
    logic                                m_sticky;
    logic                                m_af;
    logic [afu_edge_pkg::CL_LEN_W-1:0]   m_cnt;
    afu_edge_pkg::wr_hdr_t               m_hdr;
    afu_edge_pkg::wr_ctrl_t              m_ctrl;

    afu_write_edge afu_write_edge_i
    (
        .clk,
        .reset,
        .afu_beat,
        .afu_almost_full,
        .pipe_almost_full,
        .free,
        .free_idx,
        .heap_wr,
        .pipe_ctrl
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % 32'(n));
    endfunction

    // Idle and non-start beats carry garbage in every field that is ignored
    function automatic afu_edge_pkg::wr_beat_t garbage_beat(input logic valid);
        afu_edge_pkg::wr_beat_t beat;
        logic [31:0]            r;
        r = $random(seed);
        beat.valid = valid;
        beat.sop = 1'b0;
        beat.cl_len = r[afu_edge_pkg::CL_LEN_W-1:0];
        beat.address = $random(seed);
        beat.data = {$random(seed), $random(seed)};
        return beat;
    endfunction

    function automatic afu_edge_pkg::wr_beat_t start_beat(input int beats);
        afu_edge_pkg::wr_beat_t beat;
        beat = garbage_beat(1'b1);
        beat.sop = 1'b1;
        beat.cl_len = afu_edge_pkg::CL_LEN_W'(beats - 1);
        // Two lines align to two, three or four lines align to four
        if (beats > 1)
            beat.address[0] = 1'b0;
        if (beats > 2)
            beat.address[1] = 1'b0;
        return beat;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        errors++;
    endtask

    // ========================================
    // One clock cycle against the model
    // ========================================

    // Called 1 ns after a rising edge; checks at the falling edge, returns after the next rise
    task automatic drive_cycle(input afu_edge_pkg::wr_beat_t beat);
        int                    pick;
        logic                  cond;
        logic                  eop;
        afu_edge_pkg::wr_hdr_t hdr;
        afu_beat = beat;
        free = 1'b0;
        // Downstream returns a random index it still holds
        if (used_q.size() > 0 && rand_below(100) < free_pct)
        begin
            pick = rand_below(used_q.size());
            free_idx = used_q[pick];
            used_q.delete(pick);
            free = 1'b1;
        end
        @(negedge clk);
        if (afu_almost_full !== m_af)
            report_mismatch("afu_almost_full", 64'(afu_almost_full), 64'(m_af));
        if (pipe_ctrl.valid !== m_ctrl.valid)
            report_mismatch("pipe_ctrl.valid", 64'(pipe_ctrl.valid), 64'(m_ctrl.valid));
        if (pipe_ctrl.valid === 1'b1)
            flits++;
        if (m_ctrl.valid && pipe_ctrl !== m_ctrl)
            report_mismatch("pipe_ctrl", 64'(pipe_ctrl), 64'(m_ctrl));
        // Later beats take their header from the start beat
        hdr = m_hdr;
        if (beat.sop)
        begin
            hdr.cl_len = beat.cl_len;
            hdr.address = beat.address;
        end
        eop = (m_cnt == hdr.cl_len);
        if (heap_wr.wen !== beat.valid)
            report_mismatch("heap_wr.wen", 64'(heap_wr.wen), 64'(beat.valid));
        if (beat.valid && free_q.size() == 0)
        begin
            $display("Free list ran empty while a beat needed a heap index");
            errors++;
        end
        else if (beat.valid)
        begin
            if (heap_wr.idx !== free_q[0])
                report_mismatch("heap_wr.idx", 64'(heap_wr.idx), 64'(free_q[0]));
            if (heap_wr.cl_num !== m_cnt)
                report_mismatch("heap_wr.cl_num", 64'(heap_wr.cl_num), 64'(m_cnt));
            if (heap_wr.data !== beat.data)
                report_mismatch("heap_wr.data", heap_wr.data, beat.data);
        end
        // Almost-full sees the free count and packet state from before the edge
        cond = pipe_almost_full || (free_q.size() <= afu_edge_pkg::MIN_FREE_SLOTS);
        m_af = cond && (!m_active || m_sticky);
        m_sticky = cond && (m_sticky || !m_active);
        m_ctrl.valid = beat.valid && eop;
        if (beat.valid)
        begin
            m_hdr = hdr;
            if (eop && free_q.size() > 0)
            begin
                m_ctrl.cl_len = hdr.cl_len;
                m_ctrl.address = hdr.address;
                m_ctrl.heap_idx = free_q.pop_front();
                used_q.push_back(m_ctrl.heap_idx);
            end
            m_cnt = eop ? '0 : m_cnt + 1'b1;
            m_active = !eop;
        end
        if (free)
            free_q.push_back(free_idx);
        @(posedge clk);
        #1;
    endtask

    task automatic wait_almost_full(input logic level);
        int cycles;
        cycles = 0;
        while (afu_almost_full !== level && cycles < TIMEOUT)
        begin
            drive_cycle(garbage_beat(1'b0));
            cycles++;
        end
        if (afu_almost_full !== level)
        begin
            $display("Timed out waiting for afu_almost_full to reach %0d", level);
            errors++;
        end
    endtask

    // The AFU holds a new packet back while almost-full is high
    task automatic send_packet(input int beats);
        wait_almost_full(1'b0);
        drive_cycle(start_beat(beats));
        for (int b = 1; b < beats; b++)
        begin
            if (rand_below(4) == 0)
                drive_cycle(garbage_beat(1'b0));
            drive_cycle(garbage_beat(1'b1));
        end
        packets++;
    endtask

    // Returns every held index and waits for an idle, open edge
    task automatic release_heap();
        int cycles;
        cycles = 0;
        free_pct = 100;
        pipe_almost_full = 1'b0;
        while (used_q.size() > 0 && cycles < TIMEOUT)
        begin
            drive_cycle(garbage_beat(1'b0));
            cycles++;
        end
        if (used_q.size() > 0)
        begin
            $display("Timed out returning heap indices");
            errors++;
        end
        wait_almost_full(1'b0);
        free_pct = 0;
    endtask

    task automatic begin_test();
        test_errors = errors;
        test_packets = packets;
        test_flits = flits;
    endtask

    task automatic end_test(input string name);
        // One idle cycle lets the last control flit show
        drive_cycle(garbage_beat(1'b0));
        if (flits - test_flits != packets - test_packets)
            report_mismatch("pipe_ctrl count", 64'(flits - test_flits),
                            64'(packets - test_packets));
        test_count++;
        if (errors == test_errors)
            $display("PASS %s", name);
        else
        begin
            failed_tests++;
            $display("FAIL %s", name);
        end
    endtask

    // ========================================
    // Test sequence
    // ========================================

    initial
    begin
        int cycles;
        reset = 1'b1;
        afu_beat = '0;
        pipe_almost_full = 1'b0;
        free = 1'b0;
        free_idx = '0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < afu_edge_pkg::HEAP_ENTRIES; i++)
            free_q.push_back(afu_edge_pkg::HEAP_IDX_W'(i));
        m_active = 1'b0;
        m_sticky = 1'b0;
        m_af = 1'b1;
        m_cnt = '0;
        m_hdr = '0;
        m_ctrl = '0;

        begin_test();
        if (afu_almost_full !== 1'b1)
            report_mismatch("afu_almost_full", 64'(afu_almost_full), 64'd1);
        if (pipe_ctrl.valid !== 1'b0)
            report_mismatch("pipe_ctrl.valid", 64'(pipe_ctrl.valid), 64'd0);
        end_test("reset_state");

        begin_test();
        free_pct = 50;
        repeat (40) send_packet(1);
        end_test("single_beat_writes");

        begin_test();
        repeat (60) send_packet(1 + rand_below(4));
        end_test("multi_beat_collapse");

        begin_test();
        free_pct = 30;
        repeat (150) send_packet(1 + rand_below(4));
        end_test("index_recycling");

        // Level is registered, so it shows one edge after the rise
        begin_test();
        release_heap();
        pipe_almost_full = 1'b1;
        drive_cycle(garbage_beat(1'b0));
        if (afu_almost_full !== 1'b1)
            report_mismatch("afu_almost_full", 64'(afu_almost_full), 64'd1);
        pipe_almost_full = 1'b0;
        end_test("almost_full_idle");

        // A packet started inside the threshold keeps an already raised level high
        begin_test();
        release_heap();
        pipe_almost_full = 1'b1;
        wait_almost_full(1'b1);
        drive_cycle(start_beat(4));
        for (int b = 1; b < 4; b++)
        begin
            drive_cycle(garbage_beat(1'b1));
            if (afu_almost_full !== 1'b1)
                report_mismatch("afu_almost_full", 64'(afu_almost_full), 64'd1);
        end
        packets++;
        pipe_almost_full = 1'b0;
        end_test("almost_full_sticky");

        begin_test();
        release_heap();
        drive_cycle(start_beat(4));
        pipe_almost_full = 1'b1;
        for (int b = 1; b < 4; b++)
        begin
            drive_cycle(garbage_beat(1'b1));
            if (afu_almost_full !== 1'b0)
                report_mismatch("afu_almost_full", 64'(afu_almost_full), 64'd0);
        end
        packets++;
        wait_almost_full(1'b1);
        pipe_almost_full = 1'b0;
        end_test("almost_full_mid_packet");

        // Single beats with no frees drain the heap down to the reserve
        begin_test();
        release_heap();
        cycles = 0;
        while (afu_almost_full !== 1'b1 && cycles < TIMEOUT)
        begin
            drive_cycle(start_beat(1));
            packets++;
            cycles++;
        end
        if (afu_almost_full !== 1'b1)
        begin
            $display("Timed out waiting for almost-full while draining the heap");
            errors++;
        end
        if (free_q.size() > afu_edge_pkg::MIN_FREE_SLOTS)
            report_mismatch("free slots", 64'(free_q.size()), 64'(afu_edge_pkg::MIN_FREE_SLOTS));
        free_pct = 50;
        wait_almost_full(1'b0);
        if (free_q.size() <= afu_edge_pkg::MIN_FREE_SLOTS)
            report_mismatch("free slots", 64'(free_q.size()), 64'(afu_edge_pkg::MIN_FREE_SLOTS));
        end_test("almost_full_heap_low");

        $display("%0d tests, %0d failed, %0d errors", test_count, failed_tests, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: afu_write_edge.f
source/afu_edge_pkg.sv
source/write_heap_ctrl.sv
source/write_packet_tracker.sv
source/write_flow_ctrl.sv
source/write_request_collapse.sv
source/afu_write_edge.sv
test/afu_write_edge_assertions.sv
test/afu_write_edge_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the write edge testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f afu_write_edge.f \
    --top-module afu_write_edge_tb -Mdir obj_dir -o afu_write_edge_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/afu_write_edge_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
exit 1
